// File: rtl/shift_stage_pkg.sv
`default_nettype none

// Shared widths, constants, enums and packet types of the shift stage.
package shift_stage_pkg;

        //////////////////////////////////////////////////
        // Widths and constants.
        //////////////////////////////////////////////////

        // Physical register index, 46 registers fit in 6 bits.
        localparam int REG_INDEX_W = 6;
        localparam int DATA_W      = 32;

        // Reading this index yields PC plus 8.
        localparam logic [REG_INDEX_W-1:0] PHY_PC = 6'd15;

        // Multiplier takes one 8-bit slice per step.
        localparam int MULT_STEPS  = 4;
        localparam int MULT_STEP_W = 8;
        localparam int STEP_IDX_W  = 2;
        localparam logic [STEP_IDX_W-1:0] LAST_STEP = STEP_IDX_W'(MULT_STEPS - 1);

        //////////////////////////////////////////////////
        // Enums.
        //////////////////////////////////////////////////

        // MUL and MLA are consumed here and leave as MOV.
        typedef enum logic [2:0] {MOV, ADD, SUB, AND, ORR, MUL, MLA} alu_op_e;

        typedef enum logic [2:0] {LSL, LSR, ASR, ROR, RRX} shift_op_e;

        typedef enum logic [1:0] {IDLE, BUSY, DONE} mult_state_e;

        //////////////////////////////////////////////////
        // Packets.
        //////////////////////////////////////////////////

        // Immediate, or register index in the low bits.
        typedef struct packed {
                logic              imm;
                logic [DATA_W-1:0] field;
        } operand_sel_t;

        // From the issue stage.
        typedef struct packed {
                logic                   valid;
                alu_op_e                op;
                shift_op_e              shift_op;
                logic                   shift_en;
                logic                   flag_update;
                logic [REG_INDEX_W-1:0] dest;
                operand_sel_t           alu_sel;
                logic [DATA_W-1:0]      alu_value;
                operand_sel_t           shift_sel;
                logic [DATA_W-1:0]      shift_value;
                logic [DATA_W-1:0]      amount_value;
                logic [DATA_W-1:0]      pc_plus_8;
        } issue_pkt_t;

        // To the ALU stage.
        typedef struct packed {
                logic                   valid;
                alu_op_e                op;
                logic                   flag_update;
                logic [REG_INDEX_W-1:0] dest;
                logic [DATA_W-1:0]      alu_value;
                logic [DATA_W-1:0]      shift_value;
                logic                   shift_carry;
        } stage_out_t;

endpackage

`default_nettype wire

// File: rtl/operand_forward.sv
`timescale 1ns/100ps
`default_nettype none

// Resolves one source operand so back to back instructions see fresh data.
module operand_forward
(
        input  shift_stage_pkg::operand_sel_t                   i_sel,
        input  logic [shift_stage_pkg::DATA_W-1:0]              i_issue_value,
        input  logic [shift_stage_pkg::REG_INDEX_W-1:0]         i_stage_dest,
        input  logic [shift_stage_pkg::DATA_W-1:0]              i_alu_value,
        input  logic                                            i_alu_valid,
        input  logic [shift_stage_pkg::DATA_W-1:0]              i_pc_plus_8,
        output logic [shift_stage_pkg::DATA_W-1:0]              o_value
);

logic [shift_stage_pkg::REG_INDEX_W-1:0] index;

// Register index sits in the low bits of the selector.
assign index = i_sel.field[shift_stage_pkg::REG_INDEX_W-1:0];

always_comb
begin
        if ( i_sel.imm )
        begin
                // Immediate operand.
                o_value = i_sel.field;
        end
        else if ( index == shift_stage_pkg::PHY_PC )
        begin
                // PC reads as PC plus 8.
                o_value = i_pc_plus_8;
        end
        else if ( index == i_stage_dest && i_alu_valid )
        begin
                // Previous instruction is in the ALU, take its result.
                o_value = i_alu_value;
        end
        else
        begin
                // Value read at issue is current.
                o_value = i_issue_value;
        end
end

endmodule

`default_nettype wire

// File: rtl/barrel_shifter.sv
`timescale 1ns/100ps
`default_nettype none

// Combinational barrel shifter with carry out.
module barrel_shifter
(
        input  logic [shift_stage_pkg::DATA_W-1:0]      i_source,
        input  logic [7:0]                              i_amount,
        input  shift_stage_pkg::shift_op_e              i_shift_op,
        input  logic                                    i_enable,
        input  logic                                    i_carry,
        output logic [shift_stage_pkg::DATA_W-1:0]      o_result,
        output logic                                    o_carry
);

// Doubled source for rotation.
logic [2*shift_stage_pkg::DATA_W-1:0] rotated;

assign rotated = {i_source, i_source} >> i_amount[4:0];

always_comb
begin
        // Default is pass through.
        o_result = i_source;
        o_carry  = i_carry;

        // RRX ignores the amount, the rest pass on zero.
        if ( i_enable && (i_shift_op == shift_stage_pkg::RRX || i_amount != 8'd0) )
        begin
                case ( i_shift_op )
                shift_stage_pkg::LSL:
                begin
                        // Carry is the last bit out. 33 and up give zero.
                        {o_carry, o_result} = {1'b0, i_source} << i_amount;
                end
                shift_stage_pkg::LSR:
                begin
                        {o_result, o_carry} = {i_source, 1'b0} >> i_amount;
                end
                shift_stage_pkg::ASR:
                begin
                        // Large amounts saturate to the sign.
                        {o_result, o_carry} = $signed({i_source, 1'b0}) >>> i_amount;
                end
                shift_stage_pkg::ROR:
                begin
                        // Multiple of 32 keeps value, carry from bit 31.
                        o_result = rotated[shift_stage_pkg::DATA_W-1:0];
                        o_carry  = rotated[shift_stage_pkg::DATA_W-1];
                end
                shift_stage_pkg::RRX:
                begin
                        o_result = {i_carry, i_source[shift_stage_pkg::DATA_W-1:1]};
                        o_carry  = i_source[0];
                end
                default:
                begin
                        o_result = i_source;
                        o_carry  = i_carry;
                end
                endcase
        end
end

endmodule

`default_nettype wire

// File: rtl/mult_step_counter.sv
`timescale 1ns/100ps
`default_nettype none

// Multiply step counter.
module mult_step_counter
(
        input  logic                                    i_clk,
        input  logic                                    i_reset,
        input  logic                                    i_clear,
        input  logic                                    i_count_en,
        output logic [shift_stage_pkg::STEP_IDX_W-1:0]  o_step,
        output logic                                    o_last_step
);

always_ff @ (posedge i_clk)
begin
        if ( i_reset || i_clear )
        begin
                o_step <= '0;
        end
        else if ( i_count_en )
        begin
                // Wrap after the final step.
                o_step <= (o_step == shift_stage_pkg::LAST_STEP) ? '0 : o_step + 1'b1;
        end
end

assign o_last_step = (o_step == shift_stage_pkg::LAST_STEP);

endmodule

`default_nettype wire

// File: rtl/mult_datapath.sv
`timescale 1ns/100ps
`default_nettype none

// Iterative multiply accumulate, one 8-bit slice of the multiplier per step.
module mult_datapath
(
        input  logic                                    i_clk,
        input  logic                                    i_load,
        input  logic                                    i_accumulate,
        input  logic                                    i_step_en,
        input  logic [shift_stage_pkg::STEP_IDX_W-1:0]  i_step,
        input  logic [shift_stage_pkg::DATA_W-1:0]      i_multiplicand,
        input  logic [shift_stage_pkg::DATA_W-1:0]      i_multiplier,
        input  logic [shift_stage_pkg::DATA_W-1:0]      i_addend,
        output logic [shift_stage_pkg::DATA_W-1:0]      o_product
);

logic [shift_stage_pkg::DATA_W-1:0]      acc;
logic [shift_stage_pkg::DATA_W-1:0]      mcand;
logic [shift_stage_pkg::DATA_W-1:0]      mplier;
logic [shift_stage_pkg::MULT_STEP_W-1:0] slice;
logic [shift_stage_pkg::DATA_W-1:0]      partial;

//////////////////////////////////////////////////

// Slice picked by the step index.
assign slice = mplier[i_step * shift_stage_pkg::MULT_STEP_W +: shift_stage_pkg::MULT_STEP_W];

always_comb
begin
        // Only the low 32 bits matter.
        partial = mcand * shift_stage_pkg::DATA_W'(slice);
        partial = partial << (i_step * shift_stage_pkg::MULT_STEP_W);
end

//////////////////////////////////////////////////

always_ff @ (posedge i_clk)
begin
        if ( i_load )
        begin
                // Operands are captured, forwarding may change later.
                acc    <= i_accumulate ? i_addend : '0;
                mcand  <= i_multiplicand;
                mplier <= i_multiplier;
        end
        else if ( i_step_en )
        begin
                acc <= acc + partial;
        end
end

assign o_product = acc;

endmodule

`default_nettype wire

// File: rtl/mult_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

// Multiply FSM and the stage clear/stall priority.
module mult_sequencer
(
        input  logic                            i_clk,
        input  logic                            i_reset,
        input  logic                            i_valid,
        input  shift_stage_pkg::alu_op_e        i_op,
        input  logic                            i_last_step,
        input  logic                            i_clear_from_writeback,
        input  logic                            i_data_stall,
        input  logic                            i_clear_from_alu,
        output logic                            o_busy,
        output logic                            o_load,
        output logic                            o_count_en,
        output logic                            o_use_product,
        output logic                            o_flush,
        output logic                            o_hold,
        output logic                            o_advance
);

shift_stage_pkg::mult_state_e state, state_nxt;
logic is_mult;

assign is_mult = i_valid && (i_op == shift_stage_pkg::MUL || i_op == shift_stage_pkg::MLA);

//////////////////////////////////////////////////

// Writeback clear, then data stall, then ALU clear.
assign o_flush   = i_clear_from_writeback || (!i_data_stall && i_clear_from_alu);
assign o_hold    = !i_clear_from_writeback && i_data_stall;
assign o_advance = !o_flush && !o_hold;

// Stall while the product is pending.
assign o_busy        = (state == shift_stage_pkg::IDLE && is_mult) ||
                       state == shift_stage_pkg::BUSY;
assign o_load        = o_advance && state == shift_stage_pkg::IDLE && is_mult;
assign o_count_en    = o_advance && state == shift_stage_pkg::BUSY;
assign o_use_product = (state == shift_stage_pkg::DONE);

//////////////////////////////////////////////////

always_comb
begin
        state_nxt = state;

        case ( state )
        shift_stage_pkg::IDLE: if ( o_load )                   state_nxt = shift_stage_pkg::BUSY;
        shift_stage_pkg::BUSY: if ( o_count_en && i_last_step ) state_nxt = shift_stage_pkg::DONE;
        shift_stage_pkg::DONE: if ( o_advance )                state_nxt = shift_stage_pkg::IDLE;
        default:                                               state_nxt = shift_stage_pkg::IDLE;
        endcase
end

// Hold keeps the state since every move needs advance.
always_ff @ (posedge i_clk)
begin
        if ( i_reset || o_flush )
        begin
                state <= shift_stage_pkg::IDLE;
        end
        else
        begin
                state <= state_nxt;
        end
end

endmodule

`default_nettype wire

// File: rtl/stage_output_reg.sv
`timescale 1ns/100ps
`default_nettype none

// Output register feeding the ALU stage.
module stage_output_reg
(
        input  logic                                    i_clk,
        input  logic                                    i_reset,
        input  logic                                    i_flush,
        input  logic                                    i_hold,
        input  logic                                    i_advance,
        input  logic                                    i_bubble,
        input  logic                                    i_use_product,
        input  shift_stage_pkg::issue_pkt_t             i_issue,
        input  logic [shift_stage_pkg::DATA_W-1:0]      i_alu_source,
        input  logic [shift_stage_pkg::DATA_W-1:0]      i_shift_result,
        input  logic                                    i_shift_carry,
        input  logic [shift_stage_pkg::DATA_W-1:0]      i_product,
        output shift_stage_pkg::stage_out_t             o_out
);

shift_stage_pkg::stage_out_t next_out;

//////////////////////////////////////////////////

always_comb
begin
        // Bubble while the multiplier runs.
        next_out.valid       = i_issue.valid && !i_bubble;
        next_out.flag_update = i_issue.flag_update;
        next_out.dest        = i_issue.dest;
        next_out.alu_value   = i_alu_source;
        next_out.shift_carry = i_shift_carry;

        // Finished multiply leaves as a move of the product.
        next_out.op          = i_use_product ? shift_stage_pkg::MOV : i_issue.op;
        next_out.shift_value = i_use_product ? i_product : i_shift_result;
end

//////////////////////////////////////////////////

always_ff @ (posedge i_clk)
begin
        if ( i_reset || i_flush )
        begin
                o_out.valid <= 1'b0;
        end
        else if ( i_hold )
        begin
                // Keep contents.
        end
        else if ( i_advance )
        begin
                o_out <= next_out;
        end
end

endmodule

`default_nettype wire

// File: rtl/shift_stage_top.sv
`timescale 1ns/100ps
`default_nettype none

// Shift stage top: forwarding, shifter, multiplier, output register.
module shift_stage_top
(
        input  logic                                    i_clk,
        input  logic                                    i_reset,
        input  shift_stage_pkg::issue_pkt_t             i_issue,
        input  logic [shift_stage_pkg::DATA_W-1:0]      i_alu_value_nxt,
        input  logic                                    i_alu_dav_nxt,
        input  logic                                    i_carry_in,
        input  logic                                    i_clear_from_writeback,
        input  logic                                    i_data_stall,
        input  logic                                    i_clear_from_alu,
        output shift_stage_pkg::stage_out_t             o_out,
        output logic                                    o_stall
);

logic [shift_stage_pkg::DATA_W-1:0]     alu_src, shift_src, shift_result, product;
logic [shift_stage_pkg::STEP_IDX_W-1:0] step;
logic shift_carry, last_step, load, count_en, use_product, flush, hold, advance;

//////////////////////////////////////////////////
// Operand forwarding.
//////////////////////////////////////////////////

operand_forward u_fwd_alu
(
        .i_sel(i_issue.alu_sel),       .i_issue_value(i_issue.alu_value),
        .i_stage_dest(o_out.dest),     .i_alu_value(i_alu_value_nxt),
        .i_alu_valid(i_alu_dav_nxt),   .i_pc_plus_8(i_issue.pc_plus_8),
        .o_value(alu_src)
);

operand_forward u_fwd_shift
(
        .i_sel(i_issue.shift_sel),     .i_issue_value(i_issue.shift_value),
        .i_stage_dest(o_out.dest),     .i_alu_value(i_alu_value_nxt),
        .i_alu_valid(i_alu_dav_nxt),   .i_pc_plus_8(i_issue.pc_plus_8),
        .o_value(shift_src)
);

//////////////////////////////////////////////////
// Shifter and multiplier.
//////////////////////////////////////////////////

barrel_shifter u_shifter
(
        .i_source(shift_src),          .i_amount(i_issue.amount_value[7:0]),
        .i_shift_op(i_issue.shift_op), .i_enable(i_issue.shift_en),
        .i_carry(i_carry_in),          .o_result(shift_result),
        .o_carry(shift_carry)
);

mult_sequencer u_seq
(
        .i_clk(i_clk), .i_reset(i_reset), .i_valid(i_issue.valid), .i_op(i_issue.op),
        .i_last_step(last_step),       .i_clear_from_writeback(i_clear_from_writeback),
        .i_data_stall(i_data_stall),   .i_clear_from_alu(i_clear_from_alu),
        .o_busy(o_stall), .o_load(load), .o_count_en(count_en),
        .o_use_product(use_product), .o_flush(flush), .o_hold(hold), .o_advance(advance)
);

// Counter restarts on a new multiply or a flush.
mult_step_counter u_cnt
(
        .i_clk(i_clk), .i_reset(i_reset), .i_clear(load || flush),
        .i_count_en(count_en), .o_step(step), .o_last_step(last_step)
);

mult_datapath u_mult
(
        .i_clk(i_clk), .i_load(load),
        .i_accumulate(i_issue.op == shift_stage_pkg::MLA),
        .i_step_en(count_en), .i_step(step),
        .i_multiplicand(shift_src), .i_multiplier(i_issue.amount_value),
        .i_addend(alu_src), .o_product(product)
);

//////////////////////////////////////////////////
// Output register.
//////////////////////////////////////////////////

stage_output_reg u_out
(
        .i_clk(i_clk), .i_reset(i_reset), .i_flush(flush), .i_hold(hold),
        .i_advance(advance), .i_bubble(o_stall), .i_use_product(use_product),
        .i_issue(i_issue), .i_alu_source(alu_src), .i_shift_result(shift_result),
        .i_shift_carry(shift_carry), .i_product(product), .o_out(o_out)
);

endmodule

`default_nettype wire

// File: bench/shift_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

module shift_stage_tb;

localparam int SHIFT_OPS = 40;
localparam int MULT_OPS = 6;
localparam int OTHER_OPS = 12;
// Each operation costs at most one multiply plus the cycles around it.
localparam int CYCLE_LIMIT = 16 + (SHIFT_OPS + MULT_OPS + OTHER_OPS) *
                             (shift_stage_pkg::MULT_STEPS + 4) * 2;

logic i_clk = 1'b0;
logic i_reset, i_alu_dav_nxt, i_carry_in, o_stall;
logic i_clear_from_writeback, i_data_stall, i_clear_from_alu;
logic [31:0] i_alu_value_nxt;
shift_stage_pkg::issue_pkt_t i_issue;
shift_stage_pkg::stage_out_t o_out;

int errors = 0;
int checks = 0;
int cycles = 0;
logic [31:0] lfsr = 32'h0c11_68d5;
logic [shift_stage_pkg::REG_INDEX_W-1:0] last_dest = '0;

shift_stage_top UUT
(
        .i_clk(i_clk), .i_reset(i_reset), .i_issue(i_issue),
        .i_alu_value_nxt(i_alu_value_nxt), .i_alu_dav_nxt(i_alu_dav_nxt),
        .i_carry_in(i_carry_in), .i_clear_from_writeback(i_clear_from_writeback),
        .i_data_stall(i_data_stall), .i_clear_from_alu(i_clear_from_alu),
        .o_out(o_out), .o_stall(o_stall)
);

always #5 i_clk = ~i_clk;

// Ends a run that stops making progress.
always @(posedge i_clk)
begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
                $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
                $display("Finished with errors");
                $finish;
        end
end

//////////////////////////////////////////////////
// Stimulus source and reference model.
//////////////////////////////////////////////////

// Fibonacci LFSR, taps 32 22 2 1, one step per bit.
function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
                feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
                lfsr = {lfsr[30:0], feedback};
                value = {value[30:0], feedback};
        end
        return value;
endfunction

// Immediate first, then PC, then the ALU result for the held destination.
function automatic logic [31:0] resolve_operand(input shift_stage_pkg::operand_sel_t sel,
        input logic [31:0] issue_value, input logic [31:0] alu_nxt, input logic dav,
        input logic [31:0] pc_plus_8);
        if (sel.imm)
                return sel.field;
        if (sel.field[5:0] == shift_stage_pkg::PHY_PC)
                return pc_plus_8;
        if (sel.field[5:0] == last_dest && dav)
                return alu_nxt;
        return issue_value;
endfunction

// Bit by bit shift, result in the low 32 bits and carry on top.
function automatic logic [32:0] model_shift(input logic [31:0] src, input logic [7:0] amount,
        input shift_stage_pkg::shift_op_e op, input logic en, input logic cin);
        logic [31:0] r;
        logic        c;
        int          n;
        r = src;
        c = cin;
        n = int'(amount);
        if (!en || (n == 0 && op != shift_stage_pkg::RRX))
                return {c, r};
        case (op)
        shift_stage_pkg::LSL:
                for (int i = 0; i < n; i++)
                begin
                        c = r[31];
                        r = {r[30:0], 1'b0};
                end
        shift_stage_pkg::LSR:
                for (int i = 0; i < n; i++)
                begin
                        c = r[0];
                        r = {1'b0, r[31:1]};
                end
        shift_stage_pkg::ASR:
                for (int i = 0; i < n; i++)
                begin
                        c = r[0];
                        r = {r[31], r[31:1]};
                end
        shift_stage_pkg::ROR:
        begin
                // Carry is the new bit 31, also for whole turns.
                for (int i = 0; i < n % 32; i++)
                        r = {r[0], r[31:1]};
                c = r[31];
        end
        default:
        begin
                c = src[0];
                r = {cin, src[31:1]};
        end
        endcase
        return {c, r};
endfunction

function automatic shift_stage_pkg::stage_out_t predict_output(
        input shift_stage_pkg::issue_pkt_t pkt, input logic [31:0] alu_nxt,
        input logic dav, input logic cin);
        shift_stage_pkg::stage_out_t exp;
        logic [31:0] a;
        logic [31:0] s;
        logic [32:0] sh;
        a = resolve_operand(pkt.alu_sel, pkt.alu_value, alu_nxt, dav, pkt.pc_plus_8);
        s = resolve_operand(pkt.shift_sel, pkt.shift_value, alu_nxt, dav, pkt.pc_plus_8);
        sh = model_shift(s, pkt.amount_value[7:0], pkt.shift_op, pkt.shift_en, cin);
        exp.valid = 1'b1;
        exp.flag_update = pkt.flag_update;
        exp.dest = pkt.dest;
        exp.alu_value = a;
        exp.shift_carry = sh[32];
        if (pkt.op == shift_stage_pkg::MUL || pkt.op == shift_stage_pkg::MLA)
        begin
                // Low word of product, plus addend for MLA.
                exp.op = shift_stage_pkg::MOV;
                exp.shift_value = s * pkt.amount_value +
                                  (pkt.op == shift_stage_pkg::MLA ? a : 32'd0);
        end
        else
        begin
                exp.op = pkt.op;
                exp.shift_value = sh[31:0];
        end
        return exp;
endfunction

// Random operands in registers 2 and 3, random destination.
function automatic shift_stage_pkg::issue_pkt_t random_packet(input shift_stage_pkg::alu_op_e op,
        input shift_stage_pkg::shift_op_e sop, input logic en, input logic [31:0] amount);
        shift_stage_pkg::issue_pkt_t pkt;
        pkt = '0;
        pkt.valid = 1'b1;
        pkt.op = op;
        pkt.shift_op = sop;
        pkt.shift_en = en;
        pkt.flag_update = 1'(random_bits(1));
        pkt.dest = 6'(random_bits(4));
        pkt.alu_sel = {1'b0, 32'd2};
        pkt.shift_sel = {1'b0, 32'd3};
        pkt.alu_value = random_bits(32);
        pkt.shift_value = random_bits(32);
        pkt.amount_value = amount;
        pkt.pc_plus_8 = random_bits(32);
        return pkt;
endfunction

//////////////////////////////////////////////////
// Drive and check tasks.
//////////////////////////////////////////////////

task automatic compare_output(input shift_stage_pkg::stage_out_t exp, input string what);
        checks++;
        assert (o_out == exp)
        else
        begin
                errors++;
                $display("Fail at %0t: %s, got %h expected %h", $time, what, o_out, exp);
        end
endtask

// Presents one instruction, waits out the stall, then checks the result.
task automatic run_instruction(input shift_stage_pkg::issue_pkt_t pkt, input logic [31:0] alu_nxt,
        input logic dav, input logic cin, input string what);
        shift_stage_pkg::stage_out_t exp;
        shift_stage_pkg::issue_pkt_t idle_pkt;
        int stalled;
        int expected_stall;
        exp = predict_output(pkt, alu_nxt, dav, cin);
        idle_pkt = pkt;
        idle_pkt.valid = 1'b0;
        stalled = 0;
        expected_stall = (pkt.op == shift_stage_pkg::MUL || pkt.op == shift_stage_pkg::MLA) ?
                         shift_stage_pkg::MULT_STEPS + 1 : 0;
        @(posedge i_clk);
        i_issue <= pkt;
        i_alu_value_nxt <= alu_nxt;
        i_alu_dav_nxt <= dav;
        i_carry_in <= cin;
        @(negedge i_clk);
        while (o_stall)
        begin
                checks++;
                assert (!o_out.valid)
                else
                begin
                        errors++;
                        $display("Fail at %0t: %s, valid output during stall", $time, what);
                end
                stalled++;
                @(negedge i_clk);
        end
        checks++;
        assert (stalled == expected_stall)
        else
        begin
                errors++;
                $display("Fail at %0t: %s, stalled %0d cycles, expected %0d", $time, what,
                         stalled, expected_stall);
        end
        // Same fields without valid keep the held destination.
        @(posedge i_clk);
        i_issue <= idle_pkt;
        @(negedge i_clk);
        compare_output(exp, what);
        last_dest = pkt.dest;
endtask

//////////////////////////////////////////////////
// Test sequence.
//////////////////////////////////////////////////

initial
begin
        shift_stage_pkg::issue_pkt_t pkt;
        shift_stage_pkg::issue_pkt_t pkt2;
        shift_stage_pkg::stage_out_t exp;
        shift_stage_pkg::stage_out_t exp2;
        logic [31:0] amount;
        i_reset = 1'b1;
        i_issue = '0;
        i_alu_value_nxt = '0;
        i_alu_dav_nxt = 1'b0;
        i_carry_in = 1'b0;
        i_clear_from_writeback = 1'b0;
        i_data_stall = 1'b0;
        i_clear_from_alu = 1'b0;
        repeat (16) @(posedge i_clk);
        i_reset <= 1'b0;
        @(negedge i_clk);
        checks++;
        assert (!o_out.valid && !o_stall)
        else
        begin
                errors++;
                $display("Fail at %0t: output valid or stall set after reset", $time);
        end

        // Eight per shift kind, amounts 0, 32, above 32 and small.
        for (int k = 0; k < SHIFT_OPS; k++)
        begin
                case (k % 4)
                0: amount = 32'd0;
                1: amount = 32'd32;
                2: amount = 32'd33 + random_bits(7);
                default: amount = random_bits(6);
                endcase
                pkt = random_packet(shift_stage_pkg::alu_op_e'(3'(k % 5)),
                                    shift_stage_pkg::shift_op_e'(3'(k / 8)), k % 8 != 7, amount);
                run_instruction(pkt, '0, 1'b0, 1'(random_bits(1)), "shift");
        end

        for (int k = 0; k < MULT_OPS; k++)
        begin
                pkt = random_packet((k % 2 == 1) ? shift_stage_pkg::MLA : shift_stage_pkg::MUL,
                                    shift_stage_pkg::LSL, 1'b0, random_bits(32));
                run_instruction(pkt, '0, 1'b0, 1'b0, "multiply");
        end

        // Forwarding against destination 5.
        pkt = random_packet(shift_stage_pkg::ORR, shift_stage_pkg::LSL, 1'b0, '0);
        pkt.dest = 6'd5;
        run_instruction(pkt, '0, 1'b0, 1'b0, "forward setup");
        pkt.alu_sel = {1'b1, 26'(random_bits(26)), 6'd5};
        run_instruction(pkt, random_bits(32), 1'b1, 1'b0, "forward immediate");
        pkt.alu_sel = {1'b0, 26'd0, shift_stage_pkg::PHY_PC};
        run_instruction(pkt, random_bits(32), 1'b1, 1'b0, "forward pc");
        pkt.shift_sel = {1'b0, 26'd0, 6'd5};
        run_instruction(pkt, random_bits(32), 1'b1, 1'b0, "forward alu result");
        run_instruction(pkt, random_bits(32), 1'b0, 1'b0, "no forward without alu result");

        // Data stall holds the output, ALU clear is ignored.
        pkt = random_packet(shift_stage_pkg::SUB, shift_stage_pkg::ASR, 1'b1, 32'd4);
        pkt2 = random_packet(shift_stage_pkg::AND, shift_stage_pkg::ROR, 1'b1, 32'd7);
        exp = predict_output(pkt, '0, 1'b0, i_carry_in);
        exp2 = predict_output(pkt2, '0, 1'b0, i_carry_in);
        @(posedge i_clk);
        i_issue <= pkt;
        i_alu_dav_nxt <= 1'b0;
        @(posedge i_clk);
        i_issue <= pkt2;
        i_data_stall <= 1'b1;
        i_clear_from_alu <= 1'b1;
        repeat (3)
        begin
                @(negedge i_clk);
                compare_output(exp, "hold under data stall");
        end
        @(posedge i_clk);
        i_data_stall <= 1'b0;
        i_clear_from_alu <= 1'b0;
        @(negedge i_clk);
        compare_output(exp, "hold at stall release");
        pkt2.valid = 1'b0;
        @(posedge i_clk);
        i_issue <= pkt2;
        @(negedge i_clk);
        compare_output(exp2, "after data stall");

        // Writeback clear wins over a data stall.
        pkt = random_packet(shift_stage_pkg::MOV, shift_stage_pkg::LSR, 1'b1, 32'd9);
        pkt2 = random_packet(shift_stage_pkg::ADD, shift_stage_pkg::LSL, 1'b1, 32'd3);
        exp = predict_output(pkt, '0, 1'b0, i_carry_in);
        exp2 = predict_output(pkt2, '0, 1'b0, i_carry_in);
        @(posedge i_clk);
        i_issue <= pkt;
        @(posedge i_clk);
        i_issue <= pkt2;
        i_data_stall <= 1'b1;
        @(negedge i_clk);
        compare_output(exp, "before writeback clear");
        @(posedge i_clk);
        i_clear_from_writeback <= 1'b1;
        @(posedge i_clk);
        i_clear_from_writeback <= 1'b0;
        i_data_stall <= 1'b0;
        @(negedge i_clk);
        checks++;
        assert (!o_out.valid)
        else
        begin
                errors++;
                $display("Fail at %0t: writeback clear under stall left output valid", $time);
        end
        pkt2.valid = 1'b0;
        @(posedge i_clk);
        i_issue <= pkt2;
        @(negedge i_clk);
        compare_output(exp2, "after writeback clear");

        // Writeback clear aborts a running multiply.
        pkt = random_packet(shift_stage_pkg::MUL, shift_stage_pkg::LSL, 1'b0, random_bits(32));
        pkt2 = random_packet(shift_stage_pkg::ORR, shift_stage_pkg::RRX, 1'b1, '0);
        exp2 = predict_output(pkt2, '0, 1'b0, i_carry_in);
        @(posedge i_clk);
        i_issue <= pkt;
        repeat (2) @(negedge i_clk);
        @(posedge i_clk);
        i_clear_from_writeback <= 1'b1;
        i_issue <= pkt2;
        @(posedge i_clk);
        i_clear_from_writeback <= 1'b0;
        @(negedge i_clk);
        checks++;
        assert (!o_out.valid && !o_stall)
        else
        begin
                errors++;
                $display("Fail at %0t: writeback clear did not abort the multiply", $time);
        end
        pkt2.valid = 1'b0;
        @(posedge i_clk);
        i_issue <= pkt2;
        @(negedge i_clk);
        compare_output(exp2, "after multiply flush");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
                $display("Finished with no errors");
        end
        else
        begin
                $display("Finished with errors");
        end
        $finish;
end

endmodule

`default_nettype wire

// File: files.f
rtl/shift_stage_pkg.sv
rtl/operand_forward.sv
rtl/barrel_shifter.sv
rtl/mult_step_counter.sv
rtl/mult_datapath.sv
rtl/mult_sequencer.sv
rtl/stage_output_reg.sv
rtl/shift_stage_top.sv
bench/shift_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the shift stage testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --top-module shift_stage_tb -f files.f \
        -o shift_stage_sim &&
./obj_dir/shift_stage_sim | tee sim.log
grep -q "Finished with no errors" sim.log && echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
